// ==== rtl/ssb_demod_pkg.sv ====
`default_nettype none

package ssb_demod_pkg;

    localparam int PART_W   = 16;          // one real or imaginary part
    localparam int SAMPLE_W = 2 * PART_W;  // im in the upper half

    typedef struct packed {
        logic signed [PART_W-1:0] im;
        logic signed [PART_W-1:0] re;
    } iq_t;

    localparam int SSB_SYMBOLS = 4;
    localparam int PBCH_SYMBOL = 0;  // output symbol roles
    localparam int SSS_SYMBOL  = 1;

    localparam real PI      = 3.14159265358979323846;
    localparam real Q15_MAX = real'(2 ** (PART_W - 1) - 1);

    // exp(-j*2*pi*k/N) in Q1.15, N = 2**nfft, evaluated at elaboration
    function automatic iq_t twiddle(input int k, input int nfft);
        real ang;
        real c_r;
        real s_r;
        int  c_i;
        int  s_i;
        iq_t w;
        ang = 2.0 * PI * real'(k) / real'(2 ** nfft);
        c_r = $cos(ang) * Q15_MAX;
        s_r = -$sin(ang) * Q15_MAX;
        // round half away from zero
        c_i = (c_r >= 0.0) ? $rtoi(c_r + 0.5) : $rtoi(c_r - 0.5);
        s_i = (s_r >= 0.0) ? $rtoi(s_r + 0.5) : $rtoi(s_r - 0.5);
        w.re = PART_W'(c_i);
        w.im = PART_W'(s_i);
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/cp_remover.sv ====
`default_nettype none

module cp_remover #(
    parameter int NFFT   = 8,
    parameter int CP_LEN = 18
) (
    input  wire                      clk_i,
    input  wire                      reset_ni,
    input  wire                      ssb_start_i,
    input  wire ssb_demod_pkg::iq_t  in_data_i,
    input  wire                      in_valid_i,
    output ssb_demod_pkg::iq_t       sym_data_o,
    output logic                     sym_valid_o,
    output logic                     sym_last_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP_W    = $clog2(CP_LEN + 1);
    localparam int SYM_W   = $clog2(ssb_demod_pkg::SSB_SYMBOLS);

    localparam logic [CP_W-1:0]  CP_LAST   = CP_W'(CP_LEN - 1);
    localparam logic [NFFT-1:0]  BODY_LAST = NFFT'(FFT_LEN - 1);
    localparam logic [SYM_W-1:0] SYM_LAST  = SYM_W'(ssb_demod_pkg::SSB_SYMBOLS - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SKIP,
        S_BODY
    } state_t;

    state_t           state;
    logic [CP_W-1:0]  cp_cnt;
    logic [NFFT-1:0]  body_cnt;
    logic [SYM_W-1:0] sym_cnt;
    logic             body_last;

    assign body_last = (body_cnt == BODY_LAST);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= S_IDLE;
            cp_cnt      <= '0;
            body_cnt    <= '0;
            sym_cnt     <= '0;
            sym_valid_o <= 1'b0;
            sym_last_o  <= 1'b0;
        end else begin
            sym_valid_o <= in_valid_i && (state == S_BODY) && !ssb_start_i;
            sym_last_o  <= in_valid_i && (state == S_BODY) && !ssb_start_i && body_last;
            if (ssb_start_i) begin // restart framing, sample in this cycle dropped
                state    <= S_SKIP;
                cp_cnt   <= '0;
                body_cnt <= '0;
                sym_cnt  <= '0;
            end else if (in_valid_i) begin
                case (state)
                    S_SKIP: begin
                        cp_cnt <= (cp_cnt == CP_LAST) ? '0 : cp_cnt + 1'b1;
                        if (cp_cnt == CP_LAST) state <= S_BODY;
                    end
                    S_BODY: begin
                        body_cnt <= body_last ? '0 : body_cnt + 1'b1;
                        if (body_last) begin
                            sym_cnt <= sym_cnt + 1'b1;
                            state   <= (sym_cnt == SYM_LAST) ? S_IDLE : S_SKIP;
                        end
                    end
                    default: ; // idle until the next start pulse
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        sym_data_o <= in_data_i;
    end

endmodule

`default_nettype wire

// ==== rtl/fft_butterfly.sv ====
`default_nettype none

module fft_butterfly (
    input  wire                      clk_i,
    input  wire ssb_demod_pkg::iq_t  a_i,
    input  wire ssb_demod_pkg::iq_t  b_i,
    input  wire ssb_demod_pkg::iq_t  w_i,
    input  wire                      en_i,
    output ssb_demod_pkg::iq_t       x_o,
    output ssb_demod_pkg::iq_t       y_o,
    output logic                     en_o
);

    logic signed [32:0] p_re;  // full w*b products
    logic signed [32:0] p_im;
    logic signed [32:0] rnd_re;
    logic signed [32:0] rnd_im;

    ssb_demod_pkg::iq_t a_q;
    logic signed [17:0] t_re_q;  // w*b back in Q1.15
    logic signed [17:0] t_im_q;
    logic               en_q;

    logic signed [18:0] sum_re;
    logic signed [18:0] sum_im;
    logic signed [18:0] dif_re;
    logic signed [18:0] dif_im;

    always_comb begin
        p_re   = w_i.re * b_i.re - w_i.im * b_i.im;
        p_im   = w_i.re * b_i.im + w_i.im * b_i.re;
        rnd_re = p_re + 33'sd16384;
        rnd_im = p_im + 33'sd16384;
    end

    // stage 1: twiddle multiply
    always_ff @(posedge clk_i) begin
        a_q    <= a_i;
        t_re_q <= rnd_re[32:15];
        t_im_q <= rnd_im[32:15];
        en_q   <= en_i;
    end

    always_comb begin
        sum_re = a_q.re + t_re_q;
        sum_im = a_q.im + t_im_q;
        dif_re = a_q.re - t_re_q;
        dif_im = a_q.im - t_im_q;
    end

    // stage 2: add/sub, halved to keep the growth inside 16 bits
    always_ff @(posedge clk_i) begin
        x_o.re <= sum_re[16:1];
        x_o.im <= sum_im[16:1];
        y_o.re <= dif_re[16:1];
        y_o.im <= dif_im[16:1];
        en_o   <= en_q;
    end

endmodule

`default_nettype wire

// ==== rtl/fft_block.sv ====
`default_nettype none

// radix-2 DIT, in place; input lands bit-reversed so bins come out in natural order.
// compute plus readout of one symbol has to finish before the next symbol is complete
module fft_block #(
    parameter int NFFT = 8
) (
    input  wire                      clk_i,
    input  wire                      reset_ni,
    input  wire ssb_demod_pkg::iq_t  sym_data_i,
    input  wire                      sym_valid_i,
    input  wire                      sym_last_i,
    output ssb_demod_pkg::iq_t       bin_data_o,
    output logic                     bin_valid_o,
    output logic                     bin_first_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int STG_W   = $clog2(NFFT + 1);

    localparam logic [NFFT-2:0]  BF_LAST    = '1;  // FFT_LEN/2 - 1
    localparam logic [NFFT-1:0]  RD_LAST    = '1;
    localparam logic [STG_W-1:0] STG_LAST   = STG_W'(NFFT - 1);
    localparam logic [1:0]       DRAIN_LAST = 2'd2; // read reg + butterfly depth

    typedef enum logic [1:0] {
        C_IDLE,
        C_RUN,
        C_DRAIN,
        C_READ
    } cstate_t;

    logic [ssb_demod_pkg::SAMPLE_W-1:0] mem [2][FFT_LEN];
    ssb_demod_pkg::iq_t tw_rom [FFT_LEN/2];

    cstate_t          cstate;
    logic             wr_bank;   // bank being filled
    logic             cmp_bank;  // bank being transformed / read out
    logic [NFFT-1:0]  fill_cnt;
    logic [STG_W-1:0] stage;
    logic [NFFT-2:0]  bf_cnt;
    logic [1:0]       drain_cnt;
    logic [NFFT-1:0]  rd_cnt;

    logic [NFFT-1:0]  bf_ext;
    logic [NFFT-1:0]  low_mask;
    logic [NFFT-1:0]  addr_a;
    logic [NFFT-1:0]  addr_b;
    logic [NFFT-2:0]  tw_idx;

    ssb_demod_pkg::iq_t rd_a_q;
    ssb_demod_pkg::iq_t rd_b_q;
    ssb_demod_pkg::iq_t tw_q;
    logic               iss_en_q;
    logic [NFFT-1:0]    wa_pipe [3];  // write-back addresses, in step with butterfly
    logic [NFFT-1:0]    wb_pipe [3];

    ssb_demod_pkg::iq_t bf_x;
    ssb_demod_pkg::iq_t bf_y;
    logic               bf_en;

    function automatic logic [NFFT-1:0] bitrev(input logic [NFFT-1:0] v);
        logic [NFFT-1:0] r;
        for (int i = 0; i < NFFT; i++) begin
            r[i] = v[NFFT-1-i];
        end
        return r;
    endfunction

    for (genvar k = 0; k < FFT_LEN/2; k++) begin : g_tw
        localparam ssb_demod_pkg::iq_t TW = ssb_demod_pkg::twiddle(k, NFFT);
        assign tw_rom[k] = TW;
    end

    // butterfly j of stage s: span 2**s, twiddle step FFT_LEN/2**(s+1)
    always_comb begin
        bf_ext   = {1'b0, bf_cnt};
        low_mask = (NFFT'(1) << stage) - NFFT'(1);
        addr_a   = ((bf_ext & ~low_mask) << 1) | (bf_ext & low_mask);
        addr_b   = addr_a | (NFFT'(1) << stage);
        tw_idx   = (bf_cnt & low_mask[NFFT-2:0]) << (NFFT - 1 - stage);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cstate      <= C_IDLE;
            wr_bank     <= 1'b0;
            cmp_bank    <= 1'b0;
            fill_cnt    <= '0;
            stage       <= '0;
            bf_cnt      <= '0;
            drain_cnt   <= '0;
            rd_cnt      <= '0;
            iss_en_q    <= 1'b0;
            bin_valid_o <= 1'b0;
            bin_first_o <= 1'b0;
        end else begin
            iss_en_q    <= (cstate == C_RUN);
            bin_valid_o <= (cstate == C_READ);
            bin_first_o <= (cstate == C_READ) && (rd_cnt == '0);
            if (sym_valid_i) begin
                fill_cnt <= sym_last_i ? '0 : fill_cnt + 1'b1;
                if (sym_last_i) wr_bank <= !wr_bank; // bank swap
            end
            case (cstate)
                C_IDLE: begin
                    if (sym_valid_i && sym_last_i) begin
                        cmp_bank <= wr_bank;
                        stage    <= '0;
                        bf_cnt   <= '0;
                        cstate   <= C_RUN;
                    end
                end
                C_RUN: begin
                    bf_cnt <= bf_cnt + 1'b1; // wraps to 0 for the next stage
                    if (bf_cnt == BF_LAST) begin
                        drain_cnt <= '0;
                        cstate    <= C_DRAIN;
                    end
                end
                C_DRAIN: begin
                    // next stage reads what this one writes back
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DRAIN_LAST) begin
                        if (stage == STG_LAST) begin
                            rd_cnt <= '0;
                            cstate <= C_READ;
                        end else begin
                            stage  <= stage + 1'b1;
                            cstate <= C_RUN;
                        end
                    end
                end
                default: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == RD_LAST) cstate <= C_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sym_valid_i) begin
            mem[wr_bank][bitrev(fill_cnt)] <= sym_data_i;
        end
        if (bf_en) begin
            mem[cmp_bank][wa_pipe[2]] <= bf_x;
            mem[cmp_bank][wb_pipe[2]] <= bf_y;
        end
        rd_a_q     <= mem[cmp_bank][addr_a];
        rd_b_q     <= mem[cmp_bank][addr_b];
        tw_q       <= tw_rom[tw_idx];
        wa_pipe[0] <= addr_a;
        wb_pipe[0] <= addr_b;
        wa_pipe[1] <= wa_pipe[0];
        wb_pipe[1] <= wb_pipe[0];
        wa_pipe[2] <= wa_pipe[1];
        wb_pipe[2] <= wb_pipe[1];
        bin_data_o <= mem[cmp_bank][rd_cnt]; // natural-order readout
    end

    fft_butterfly fft_butterfly_i (
        .clk_i (clk_i),
        .a_i   (rd_a_q),
        .b_i   (rd_b_q),
        .w_i   (tw_q),
        .en_i  (iss_en_q),
        .x_o   (bf_x),
        .y_o   (bf_y),
        .en_o  (bf_en)
    );

endmodule

`default_nettype wire

// ==== rtl/symbol_tagger.sv ====
`default_nettype none

module symbol_tagger (
    input  wire                      clk_i,
    input  wire                      reset_ni,
    input  wire                      ssb_start_i,
    input  wire ssb_demod_pkg::iq_t  bin_data_i,
    input  wire                      bin_valid_i,
    input  wire                      bin_first_i,
    output ssb_demod_pkg::iq_t       out_data_o,
    output logic                     out_valid_o,
    output logic                     symbol_start_o,
    output logic                     pbch_start_o,
    output logic                     pbch_valid_o,
    output logic                     sss_start_o,
    output logic                     sss_valid_o
);

    localparam int SYM_W = $clog2(ssb_demod_pkg::SSB_SYMBOLS + 1);

    localparam logic [SYM_W-1:0] SYM_END  = SYM_W'(ssb_demod_pkg::SSB_SYMBOLS);
    localparam logic [SYM_W-1:0] PBCH_IDX = SYM_W'(ssb_demod_pkg::PBCH_SYMBOL);
    localparam logic [SYM_W-1:0] SSS_IDX  = SYM_W'(ssb_demod_pkg::SSS_SYMBOL);

    logic [SYM_W-1:0] out_sym;  // output symbol within the SSB
    logic             is_pbch;
    logic             is_sss;
    logic             sym_done;

    assign is_pbch  = (out_sym == PBCH_IDX);
    assign is_sss   = (out_sym == SSS_IDX);
    assign sym_done = out_valid_o && !bin_valid_i; // bins of one symbol are back to back

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_sym <= '0;
        end else if (ssb_start_i) begin
            out_sym <= '0;
        end else if (sym_done && (out_sym != SYM_END)) begin
            out_sym <= out_sym + 1'b1; // holds at SYM_END, no roles past it
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o    <= 1'b0;
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            pbch_valid_o   <= 1'b0;
            sss_start_o    <= 1'b0;
            sss_valid_o    <= 1'b0;
        end else begin
            out_valid_o    <= bin_valid_i;
            symbol_start_o <= bin_first_i;
            pbch_start_o   <= bin_first_i && is_pbch;
            pbch_valid_o   <= bin_valid_i && is_pbch;
            sss_start_o    <= bin_first_i && is_sss;
            sss_valid_o    <= bin_valid_i && is_sss;
        end
    end

    // data in step with the flags
    always_ff @(posedge clk_i) begin
        out_data_o <= bin_data_i;
    end

endmodule

`default_nettype wire

// ==== rtl/ssb_demod.sv ====
`default_nettype none

module ssb_demod #(
    parameter int NFFT   = 8,   // log2 of the FFT length
    parameter int CP_LEN = 18
) (
    input  wire                      clk_i,
    input  wire                      reset_ni,
    input  wire                      ssb_start_i,
    input  wire ssb_demod_pkg::iq_t  in_data_i,
    input  wire                      in_valid_i,
    output ssb_demod_pkg::iq_t       out_data_o,
    output logic                     out_valid_o,
    output logic                     symbol_start_o,
    output logic                     pbch_start_o,
    output logic                     pbch_valid_o,
    output logic                     sss_start_o,
    output logic                     sss_valid_o
);

    wire ssb_demod_pkg::iq_t sym_data;  // prefix removed, time domain
    wire                     sym_valid;
    wire                     sym_last;
    wire ssb_demod_pkg::iq_t bin_data;  // frequency domain, natural order
    wire                     bin_valid;
    wire                     bin_first;

    cp_remover #(
        .NFFT   (NFFT),
        .CP_LEN (CP_LEN)
    ) cp_remover_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .ssb_start_i (ssb_start_i),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .sym_data_o  (sym_data),
        .sym_valid_o (sym_valid),
        .sym_last_o  (sym_last)
    );

    fft_block #(
        .NFFT (NFFT)
    ) fft_block_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sym_data_i  (sym_data),
        .sym_valid_i (sym_valid),
        .sym_last_i  (sym_last),
        .bin_data_o  (bin_data),
        .bin_valid_o (bin_valid),
        .bin_first_o (bin_first)
    );

    symbol_tagger symbol_tagger_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .ssb_start_i    (ssb_start_i),
        .bin_data_i     (bin_data),
        .bin_valid_i    (bin_valid),
        .bin_first_i    (bin_first),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_start_o    (sss_start_o),
        .sss_valid_o    (sss_valid_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_ssb_demod.sv ====
`default_nettype none

module tb_ssb_demod;

    localparam int NFFT         = 4;
    localparam int CP_LEN       = 4;
    localparam int FFT_LEN      = 2 ** NFFT;
    localparam int PART_W       = ssb_demod_pkg::PART_W;
    localparam int SYMS         = ssb_demod_pkg::SSB_SYMBOLS;
    localparam int BINS         = SYMS * FFT_LEN;  // output bins per SSB
    localparam int ROWS         = 3;
    localparam int WDOG_CYCLES  = ROWS * SYMS * (CP_LEN + FFT_LEN) * 8 + 500;
    localparam int QUIET_CYCLES = 80;   // longer than one symbol's latency
    localparam int WAIT_LIMIT   = 200;
    localparam real PI          = 3.14159265358979323846;

    localparam int IMPULSE = 0;
    localparam int TONE    = 1;
    localparam int RANDOM  = 2;

    typedef struct packed {
        int kind;
        int bin;      // tone bin
        int amp;
        int garbage;  // prefix filled with full-scale values
    } sym_pat_t;

    // one SSB per row, one pattern per symbol
    sym_pat_t stim_tab [ROWS][SYMS] = '{
        '{'{IMPULSE, 0, 8000, 0}, '{TONE, 3, 6000, 0},
          '{TONE, 10, 4000, 0}, '{RANDOM, 0, 12000, 0}},
        '{'{IMPULSE, 0, 20000, 1}, '{RANDOM, 0, 12000, 0},
          '{TONE, 1, 9000, 1}, '{RANDOM, 0, 3000, 1}},
        '{'{RANDOM, 0, 12000, 1}, '{RANDOM, 0, 12000, 0},
          '{TONE, 0, 5000, 0}, '{IMPULSE, 0, -7000, 0}}
    };

    logic               clk_i;
    logic               reset_ni;
    logic               ssb_start_i;
    ssb_demod_pkg::iq_t in_data_i;
    logic               in_valid_i;
    ssb_demod_pkg::iq_t out_data_o;
    logic               out_valid_o;
    logic               symbol_start_o;
    logic               pbch_start_o;
    logic               pbch_valid_o;
    logic               sss_start_o;
    logic               sss_valid_o;

    ssb_demod_pkg::iq_t body [SYMS][FFT_LEN];  // time-domain symbol without prefix
    ssb_demod_pkg::iq_t exp_bins [BINS];
    ssb_demod_pkg::iq_t got_bins [$];
    logic [4:0]         got_flags [$];  // symbol, pbch start/valid, sss start/valid
    int                 value_errors;
    int                 flag_errors;
    int                 frame_errors;

    ssb_demod #(
        .NFFT   (NFFT),
        .CP_LEN (CP_LEN)
    ) dut_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .ssb_start_i    (ssb_start_i),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_start_o    (sss_start_o),
        .sss_valid_o    (sss_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    // outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (out_valid_o === 1'b1) begin
            got_bins.push_back(out_data_o);
            got_flags.push_back({symbol_start_o, pbch_start_o, pbch_valid_o,
                                 sss_start_o, sss_valid_o});
        end else if ({out_valid_o, symbol_start_o, pbch_start_o, pbch_valid_o,
                      sss_start_o, sss_valid_o} !== 6'b0) begin
            $display("%0t: out_valid_o or a flag is high or unknown outside a valid bin",
                     $time);
            frame_errors++;
        end
    end

    function automatic int round_int(input real x);
        return (x >= 0.0) ? $rtoi(x + 0.5) : $rtoi(x - 0.5);
    endfunction

    function automatic int rand_part(input int amp);
        return int'($urandom % 32'(2 * amp + 1)) - amp;
    endfunction

    function automatic ssb_demod_pkg::iq_t pattern_sample(input sym_pat_t p, input int n);
        ssb_demod_pkg::iq_t s;
        real                ang;
        s   = '0;
        ang = 2.0 * PI * real'(p.bin * n) / real'(FFT_LEN);
        case (p.kind)
            IMPULSE: s.re = (n == 0) ? PART_W'(p.amp) : '0;
            TONE: begin
                s.re = PART_W'(round_int(real'(p.amp) * $cos(ang)));
                s.im = PART_W'(round_int(real'(p.amp) * $sin(ang)));
            end
            default: begin
                s.re = PART_W'(rand_part(p.amp));
                s.im = PART_W'(rand_part(p.amp));
            end
        endcase
        return s;
    endfunction

    // cyclic copy of the body tail, or full-scale junk
    function automatic ssb_demod_pkg::iq_t prefix_sample(input sym_pat_t p, input int sym,
                                                         input int i);
        ssb_demod_pkg::iq_t s;
        if (p.garbage != 0) begin
            s.re = (i % 2 == 0) ? 16'sh7fff : 16'sh8000;
            s.im = (i % 2 == 0) ? 16'sh8000 : 16'sh7fff;
        end else begin
            s = body[sym][FFT_LEN-CP_LEN+i];
        end
        return s;
    endfunction

    // reference DFT scaled by 1/FFT_LEN
    task automatic compute_expected(input int sym);
        real acc_re;
        real acc_im;
        real ang;
        for (int k = 0; k < FFT_LEN; k++) begin
            acc_re = 0.0;
            acc_im = 0.0;
            for (int n = 0; n < FFT_LEN; n++) begin
                ang    = -2.0 * PI * real'(k * n) / real'(FFT_LEN);
                acc_re += real'(body[sym][n].re) * $cos(ang) - real'(body[sym][n].im) * $sin(ang);
                acc_im += real'(body[sym][n].re) * $sin(ang) + real'(body[sym][n].im) * $cos(ang);
            end
            exp_bins[sym*FFT_LEN+k].re = PART_W'(round_int(acc_re / real'(FFT_LEN)));
            exp_bins[sym*FFT_LEN+k].im = PART_W'(round_int(acc_im / real'(FFT_LEN)));
        end
    endtask

    task automatic check_bin(input ssb_demod_pkg::iq_t got, input ssb_demod_pkg::iq_t exp,
                             input string what);
        int d_re;
        int d_im;
        d_re = int'(got.re) - int'(exp.re);
        d_im = int'(got.im) - int'(exp.im);
        if (d_re > NFFT || d_re < -NFFT || d_im > NFFT || d_im < -NFFT) begin
            $display("MISMATCH %0t: %s got (%0d, %0d) expected (%0d, %0d)", $time, what,
                     got.re, got.im, exp.re, exp.im);
            value_errors++;
        end
    endtask

    task automatic check_flags(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    // one valid cycle, then an idle gap of 3 to 6 cycles
    task automatic send_sample(input ssb_demod_pkg::iq_t s);
        int gap;
        gap = 2 + int'($urandom % 4);
        @(negedge clk_i);
        in_data_i  = s;
        in_valid_i = 1'b1;
        @(negedge clk_i);
        in_valid_i = 1'b0;
        repeat (gap) @(negedge clk_i);
    endtask

    task automatic send_random_samples(input int count);
        for (int i = 0; i < count; i++) begin
            send_sample('{im: PART_W'(rand_part(12000)), re: PART_W'(rand_part(12000))});
        end
    endtask

    task automatic pulse_start();
        @(negedge clk_i);
        ssb_start_i = 1'b1;
        @(negedge clk_i);
        ssb_start_i = 1'b0;
    endtask

    task automatic compare_outputs(input int row);
        ssb_demod_pkg::iq_t got;
        logic [4:0]         f;
        int                 n_got;
        int                 sym;
        int                 bin;
        string              where;
        n_got = (got_bins.size() < BINS) ? got_bins.size() : BINS;
        for (int i = 0; i < n_got; i++) begin
            sym   = i / FFT_LEN;
            bin   = i % FFT_LEN;
            got   = got_bins.pop_front();
            f     = got_flags.pop_front();
            where = $sformatf("row %0d symbol %0d bin %0d", row, sym, bin);
            check_bin(got, exp_bins[i], where);
            check_flags(f[4], bin == 0, {where, " symbol_start_o"});
            check_flags(f[3], sym == ssb_demod_pkg::PBCH_SYMBOL && bin == 0,
                        {where, " pbch_start_o"});
            check_flags(f[2], sym == ssb_demod_pkg::PBCH_SYMBOL, {where, " pbch_valid_o"});
            check_flags(f[1], sym == ssb_demod_pkg::SSS_SYMBOL && bin == 0,
                        {where, " sss_start_o"});
            check_flags(f[0], sym == ssb_demod_pkg::SSS_SYMBOL, {where, " sss_valid_o"});
        end
    endtask

    task automatic run_row(input int row);
        int waited;
        for (int sym = 0; sym < SYMS; sym++) begin
            for (int n = 0; n < FFT_LEN; n++) body[sym][n] = pattern_sample(stim_tab[row][sym], n);
            compute_expected(sym);
        end
        pulse_start();
        for (int sym = 0; sym < SYMS; sym++) begin
            for (int i = 0; i < CP_LEN; i++) send_sample(prefix_sample(stim_tab[row][sym], sym, i));
            for (int n = 0; n < FFT_LEN; n++) send_sample(body[sym][n]);
        end
        waited = 0;
        while (got_bins.size() < BINS && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (got_bins.size() < BINS) begin
            $display("row %0d: only %0d of %0d output bins arrived", row, got_bins.size(), BINS);
            frame_errors++;
        end
        compare_outputs(row);
        // a whole fifth symbol, nothing may come out of it
        send_random_samples(CP_LEN + FFT_LEN);
        repeat (QUIET_CYCLES) @(posedge clk_i);
        if (got_bins.size() != 0) begin
            $display("row %0d: %0d extra output bins after the fourth symbol", row,
                     got_bins.size());
            frame_errors++;
            got_bins.delete();
            got_flags.delete();
        end
    endtask

    initial begin
        value_errors = 0;
        flag_errors  = 0;
        frame_errors = 0;
        reset_ni     = 1'b0;
        ssb_start_i  = 1'b0;
        in_data_i    = '0;
        in_valid_i   = 1'b0;
        void'($urandom(32'h22d9));
        repeat (4) @(negedge clk_i);
        reset_ni = 1'b1;
        // a full symbol of samples before any start pulse
        send_random_samples(CP_LEN + FFT_LEN);
        repeat (QUIET_CYCLES) @(posedge clk_i);
        if (got_bins.size() != 0) begin
            $display("output appeared before the first start pulse (%0d bins)", got_bins.size());
            frame_errors++;
            got_bins.delete();
            got_flags.delete();
        end
        for (int row = 0; row < ROWS; row++) run_row(row);
        $display("value mismatches: %0d, flag mismatches: %0d, framing errors: %0d",
                 value_errors, flag_errors, frame_errors);
        if (value_errors + flag_errors + frame_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/ssb_demod_pkg.sv
rtl/cp_remover.sv
rtl/fft_butterfly.sv
rtl/fft_block.sv
rtl/symbol_tagger.sv
rtl/ssb_demod.sv
bench/tb_ssb_demod.sv
